//--- cache_pkt_engine.f
source/cache_op_pkg.sv
source/cache_geom_pkg.sv
source/cache_pkt_decode.sv
source/cache_execute.sv
source/cache_result.sv
source/cache_pkt_engine.sv
bench/cache_pkt_engine_sva.sv
bench/cache_pkt_engine_tb.sv

//--- Bender.yml
package:
  name: cache_pkt_engine

sources:
  # packages first, then the RTL bottom up
  - source/cache_op_pkg.sv
  - source/cache_geom_pkg.sv
  - source/cache_pkt_decode.sv
  - source/cache_execute.sv
  - source/cache_result.sv
  - source/cache_pkt_engine.sv
  - target: test
    files:
      - bench/cache_pkt_engine_sva.sv
      - bench/cache_pkt_engine_tb.sv

//--- bench/cache_pkt_engine_tb.sv
`default_nettype none

module cache_pkt_engine_tb
  import cache_op_pkg::*;
  import cache_geom_pkg::*;
();

  localparam int lines_lp = 16;
  localparam int kind_data_lp = 0;
  localparam int kind_taglv_lp = 1;
  localparam int kind_tagla_lp = 2;

  localparam logic [opcode_width_c-1:0] st_ops [4] = '{SB, SH, SW, SD};
  localparam logic [opcode_width_c-1:0] lds_ops [4] = '{LB, LH, LW, LD};
  localparam logic [opcode_width_c-1:0] ldu_ops [4] = '{LBU, LHU, LWU, LDU};

  logic clk_i;
  logic arst_n_i;
  logic v_i;
  logic [opcode_width_c-1:0] opcode_i;
  logic [addr_width_c-1:0] addr_i;
  logic [data_width_c-1:0] data_i;
  logic [data_width_c/8-1:0] mask_i;
  logic v_o;
  logic [data_width_c-1:0] data_o;

  // reference model of the arrays
  logic [data_width_c-1:0] model_mem [lines_lp];
  pkt_data_u model_tag [lines_lp];

  logic [data_width_c-1:0] exp_q [$];
  int kind_q [$];
  int due_q [$];
  int cycle = 0;
  int data_errs = 0;
  int tag_errs = 0;
  int other_errs = 0;
  string test_name = "none";

  cache_pkt_engine #(
    .lines_p (lines_lp)
  ) UUT (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (v_i),
    .opcode_i (opcode_i),
    .addr_i   (addr_i),
    .data_i   (data_i),
    .mask_i   (mask_i),
    .v_o      (v_o),
    .data_o   (data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle++;
  end

  task automatic check_data(input string name, input logic [data_width_c-1:0] exp,
                            input logic [data_width_c-1:0] act);
    if (act !== exp) begin
      data_errs++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input pkt_data_u exp, input pkt_data_u act);
    if (act !== exp) begin
      tag_errs++;
      $display("ERR %s: expected lock %b valid %b line %h pad %h", name,
               exp.tag.lock, exp.tag.valid, exp.tag.line_addr, exp.tag.pad);
      $display("ERR %s: actual lock %b valid %b line %h pad %h", name,
               act.tag.lock, act.tag.valid, act.tag.line_addr, act.tag.pad);
    end
  endtask

  // stray bits outside the returned field land in pad
  always @(negedge clk_i) begin : monitor
    logic [data_width_c-1:0] exp;
    pkt_data_u act_tag;
    int kind;
    int due;
    if (arst_n_i && v_o) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("%s: result arrived with no packet outstanding", test_name);
      end else begin
        exp = exp_q.pop_front();
        kind = kind_q.pop_front();
        due = due_q.pop_front();
        if (due != cycle) begin
          other_errs++;
          $display("%s: result came in cycle %0d, not %0d", test_name, cycle, due);
        end
        act_tag = '0;
        if (kind == kind_taglv_lp) begin
          act_tag.tag.lock = data_o[1];
          act_tag.tag.valid = data_o[0];
          act_tag.tag.pad = |data_o[data_width_c-1:2];
          check_tag(test_name, exp, act_tag);
        end else if (kind == kind_tagla_lp) begin
          act_tag.tag.line_addr = data_o[addr_width_c-1:byte_offset_width_c];
          act_tag.tag.pad = |{data_o[data_width_c-1:addr_width_c], data_o[2:0]};
          check_tag(test_name, exp, act_tag);
        end else begin
          check_data(test_name, exp, data_o);
        end
      end
    end
  end

  task automatic issue(input logic [opcode_width_c-1:0] op,
                       input logic [addr_width_c-1:0] addr,
                       input logic [data_width_c-1:0] data,
                       input logic [data_width_c/8-1:0] mask,
                       input int kind, input logic [data_width_c-1:0] exp);
    @(negedge clk_i);
    v_i = 1'b1;
    opcode_i = op;
    addr_i = addr;
    data_i = data;
    mask_i = mask;
    exp_q.push_back(exp);
    kind_q.push_back(kind);
    // sampled on the next edge, result registered one edge later
    due_q.push_back(cycle + 2);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk_i);
    v_i = 1'b0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%s: timed out waiting for v_o, %0d results missing", test_name, exp_q.size());
      exp_q.delete();
      kind_q.delete();
      due_q.delete();
    end
  endtask

  // random byte address whose line maps to idx
  function automatic logic [addr_width_c-1:0] addr_for(input int idx);
    logic [line_addr_width_c-1:0] line;
    logic [byte_offset_width_c-1:0] off;
    line = $urandom;
    line = line - (line % lines_lp) + idx;
    off = $urandom;
    return {line, off};
  endfunction

  function automatic logic [data_width_c-1:0] load_value(input logic [data_width_c-1:0] word,
      input int size, input int offset, input bit sign);
    int nbytes;
    int lane;
    logic [data_width_c-1:0] val;
    nbytes = 1 << size;
    lane = offset - (offset % nbytes);
    val = '0;
    for (int k = 0; k < nbytes; k++) begin
      val[8*k +: 8] = word[8*(lane+k) +: 8];
    end
    if (sign && val[8*nbytes-1]) begin
      for (int k = nbytes; k < 8; k++) begin
        val[8*k +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  function automatic void store_model(input int idx, input int size, input int offset,
                                      input logic [data_width_c-1:0] data);
    int nbytes;
    int lane;
    nbytes = 1 << size;
    lane = offset - (offset % nbytes);
    for (int k = 0; k < nbytes; k++) begin
      model_mem[idx][8*(lane+k) +: 8] = data[8*k +: 8];
    end
  endfunction

  task automatic read_tags(input logic [addr_width_c-1:0] addr);
    pkt_data_u lv;
    pkt_data_u la;
    int idx;
    idx = (addr >> byte_offset_width_c) % lines_lp;
    lv = '0;
    lv.tag.lock = model_tag[idx].tag.lock;
    lv.tag.valid = model_tag[idx].tag.valid;
    la = '0;
    la.tag.line_addr = model_tag[idx].tag.line_addr;
    issue(TAGLV, addr, '0, '0, kind_taglv_lp, lv);
    issue(TAGLA, addr, '0, '0, kind_tagla_lp, la);
  endtask

  task automatic test_reset();
    test_name = "reset";
    for (int i = 0; i < lines_lp; i++) begin
      issue(TAGLV, addr_for(i), '0, '0, kind_taglv_lp, '0);
    end
    issue(LD, addr_for($urandom % lines_lp), '0, '0, kind_data_lp, '0);
    drain();
  endtask

  task automatic test_load_store();
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
    logic [data_width_c-1:0] exp;
    int idx;
    test_name = "load_store";
    for (int size = 0; size < 4; size++) begin
      for (int off = 0; off < 8; off += (1 << size)) begin
        idx = $urandom % lines_lp;
        addr = addr_for(idx);
        addr[2:0] = off[2:0];
        data = {$urandom, $urandom};
        store_model(idx, size, off, data);
        issue(st_ops[size], addr, data, '0, kind_data_lp, '0);
        for (int ls = 0; ls < 4; ls++) begin
          exp = load_value(model_mem[idx], ls, off, 1'b1);
          issue(lds_ops[ls], addr, '0, '0, kind_data_lp, exp);
          exp = load_value(model_mem[idx], ls, off, 1'b0);
          issue(ldu_ops[ls], addr, '0, '0, kind_data_lp, exp);
        end
      end
    end
    drain();
  endtask

  task automatic test_masked();
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
    logic [data_width_c-1:0] exp;
    logic [data_width_c/8-1:0] mask;
    int idx;
    test_name = "masked";
    for (int n = 0; n < 8; n++) begin
      idx = $urandom % lines_lp;
      addr = addr_for(idx);
      data = {$urandom, $urandom};
      mask = $urandom;
      for (int k = 0; k < 8; k++) begin
        if (mask[k]) begin
          model_mem[idx][8*k +: 8] = data[8*k +: 8];
        end
      end
      issue(SM, addr, data, mask, kind_data_lp, '0);
      mask = $urandom;
      for (int k = 0; k < 8; k++) begin
        exp[8*k +: 8] = mask[k] ? model_mem[idx][8*k +: 8] : 8'h00;
      end
      issue(LM, addr, '0, mask, kind_data_lp, exp);
    end
    drain();
  endtask

  task automatic test_tags();
    pkt_data_u view;
    logic [addr_width_c-1:0] addr;
    int idx;
    test_name = "tags";
    for (int i = 0; i < lines_lp; i++) begin
      view = {$urandom, $urandom};
      addr = addr_for(i);
      model_tag[i] = '0;
      model_tag[i].tag.lock = view.tag.lock;
      model_tag[i].tag.valid = view.tag.valid;
      model_tag[i].tag.line_addr = view.tag.line_addr;
      issue(TAGST, addr, view, '0, kind_data_lp, '0);
      read_tags(addr);
    end
    // each op uses a fresh address on the same line
    // lock ops come first while valid still holds the stored bit
    for (idx = 0; idx < lines_lp; idx++) begin
      issue(AUNLOCK, addr_for(idx), '0, '0, kind_data_lp, '0);
      model_tag[idx].tag.lock = 1'b0;
      read_tags(addr_for(idx));
      issue(ALOCK, addr_for(idx), '0, '0, kind_data_lp, '0);
      model_tag[idx].tag.lock = 1'b1;
      read_tags(addr_for(idx));
      issue(AINV, addr_for(idx), '0, '0, kind_data_lp, '0);
      model_tag[idx].tag.valid = 1'b0;
      model_tag[idx].tag.lock = 1'b0;
      read_tags(addr_for(idx));
    end
    drain();
  endtask

  task automatic test_back_to_back();
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
    int idx;
    int size;
    test_name = "back_to_back";
    for (int n = 0; n < 12; n++) begin
      idx = $urandom % lines_lp;
      addr = addr_for(idx);
      size = $urandom % 4;
      data = {$urandom, $urandom};
      store_model(idx, size, addr[2:0], data);
      issue(st_ops[size], addr, data, '0, kind_data_lp, '0);
      issue(LD, addr, '0, '0, kind_data_lp, model_mem[idx]);
    end
    drain();
  endtask

  initial begin : main
    void'($urandom(21649));
    arst_n_i = 1'b0;
    v_i = 1'b0;
    opcode_i = '0;
    addr_i = '0;
    data_i = '0;
    mask_i = '0;
    for (int i = 0; i < lines_lp; i++) begin
      model_mem[i] = '0;
      model_tag[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    test_reset();
    test_load_store();
    test_masked();
    test_tags();
    test_back_to_back();
    $display("errors: data %0d, tag %0d, other %0d", data_errs, tag_errs, other_errs);
    if (data_errs + tag_errs + other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/cache_pkt_engine_sva.sv
`default_nettype none

module cache_pkt_engine_sva
  import cache_geom_pkg::*;
(
  input wire logic                    clk_i,
  input wire logic                    arst_n_i,
  input wire logic                    ex_v_i,
  input wire logic                    ex_ld_i,
  input wire logic                    ex_taglv_i,
  input wire logic                    ex_tagla_i,
  input wire logic                    v_o,
  input wire logic [data_width_c-1:0] data_o
);

  reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !v_o)
    else $error("v_o high while reset is active");

  // one cycle from execute to result
  valid_follows: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ex_v_i |=> v_o)
    else $error("v_o missing one cycle after ex_v_i");

  no_extra_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !ex_v_i |=> !v_o)
    else $error("v_o high without ex_v_i the cycle before");

  zero_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ex_v_i && !ex_ld_i && !ex_taglv_i && !ex_tagla_i) |=> (data_o == '0))
    else $error("data_o nonzero after a non-returning packet");

endmodule

bind cache_result cache_pkt_engine_sva u_sva (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .ex_v_i     (ex_v_i),
  .ex_ld_i    (ex_ld_i),
  .ex_taglv_i (ex_taglv_i),
  .ex_tagla_i (ex_tagla_i),
  .v_o        (v_o),
  .data_o     (data_o)
);

`default_nettype wire

//--- source/cache_pkt_engine.sv
`default_nettype none

module cache_pkt_engine
  import cache_op_pkg::*;
  import cache_geom_pkg::*;
#(
  parameter int lines_p = 16
) (
  input  wire logic                      clk_i,
  input  wire logic                      arst_n_i,
  input  wire logic                      v_i,
  input  wire logic [opcode_width_c-1:0] opcode_i,
  input  wire logic [addr_width_c-1:0]   addr_i,
  input  wire logic [data_width_c-1:0]   data_i,
  input  wire logic [data_width_c/8-1:0] mask_i,
  output logic                           v_o,
  output logic [data_width_c-1:0]        data_o
);

  // decode flags
  logic [1:0] data_size;
  logic sigext;
  logic ld;
  logic st;
  logic mask_op;
  logic tagst;
  logic taglv;
  logic tagla;
  logic ainv;
  logic alock;
  logic aunlock;

  // execute stage outputs
  logic ex_v;
  logic [data_width_c-1:0] rd_data;
  pkt_data_u rd_tag;
  logic [1:0] ex_size;
  logic ex_sigext;
  logic ex_ld;
  logic ex_mask_op;
  logic ex_taglv;
  logic ex_tagla;
  logic [byte_offset_width_c-1:0] ex_offset;
  logic [data_width_c/8-1:0] ex_mask;

  cache_pkt_decode u_decode (
    .opcode_i    (opcode_i),
    .data_size_o (data_size),
    .sigext_o    (sigext),
    .ld_o        (ld),
    .st_o        (st),
    .mask_op_o   (mask_op),
    .tagst_o     (tagst),
    .taglv_o     (taglv),
    .tagla_o     (tagla),
    .ainv_o      (ainv),
    .alock_o     (alock),
    .aunlock_o   (aunlock)
  );

  cache_execute #(
    .lines_p (lines_p)
  ) u_execute (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .v_i          (v_i),
    .addr_i       (addr_i),
    .data_i       (data_i),
    .mask_i       (mask_i),
    .data_size_i  (data_size),
    .sigext_i     (sigext),
    .ld_i         (ld),
    .st_i         (st),
    .mask_op_i    (mask_op),
    .tagst_i      (tagst),
    .taglv_i      (taglv),
    .tagla_i      (tagla),
    .ainv_i       (ainv),
    .alock_i      (alock),
    .aunlock_i    (aunlock),
    .ex_v_o       (ex_v),
    .rd_data_o    (rd_data),
    .rd_tag_o     (rd_tag),
    .ex_size_o    (ex_size),
    .ex_sigext_o  (ex_sigext),
    .ex_ld_o      (ex_ld),
    .ex_mask_op_o (ex_mask_op),
    .ex_taglv_o   (ex_taglv),
    .ex_tagla_o   (ex_tagla),
    .ex_offset_o  (ex_offset),
    .ex_mask_o    (ex_mask)
  );

  cache_result u_result (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ex_v_i       (ex_v),
    .rd_data_i    (rd_data),
    .rd_tag_i     (rd_tag),
    .ex_size_i    (ex_size),
    .ex_sigext_i  (ex_sigext),
    .ex_ld_i      (ex_ld),
    .ex_mask_op_i (ex_mask_op),
    .ex_taglv_i   (ex_taglv),
    .ex_tagla_i   (ex_tagla),
    .ex_offset_i  (ex_offset),
    .ex_mask_i    (ex_mask),
    .v_o          (v_o),
    .data_o       (data_o)
  );

endmodule

`default_nettype wire

//--- source/cache_result.sv
`default_nettype none

module cache_result
  import cache_op_pkg::*;
  import cache_geom_pkg::*;
(
  input  wire logic                           clk_i,
  input  wire logic                           arst_n_i,
  input  wire logic                           ex_v_i,
  input  wire logic [data_width_c-1:0]        rd_data_i,
  input  wire pkt_data_u                      rd_tag_i,
  input  wire logic [1:0]                     ex_size_i,
  input  wire logic                           ex_sigext_i,
  input  wire logic                           ex_ld_i,
  input  wire logic                           ex_mask_op_i,
  input  wire logic                           ex_taglv_i,
  input  wire logic                           ex_tagla_i,
  input  wire logic [byte_offset_width_c-1:0] ex_offset_i,
  input  wire logic [data_width_c/8-1:0]      ex_mask_i,
  output logic                                v_o,
  output logic [data_width_c-1:0]             data_o
);

  logic [byte_offset_width_c-1:0] lane;
  logic [data_width_c-1:0] shifted;
  logic [data_width_c-1:0] result;

  // lane of the access, aligned to its size
  always_comb begin
    case (ex_size_i)
      size_byte_c: lane = ex_offset_i;
      size_half_c: lane = {ex_offset_i[2:1], 1'b0};
      size_word_c: lane = {ex_offset_i[2], 2'b00};
      default: lane = '0;
    endcase
  end

  assign shifted = rd_data_i >> {lane, 3'b000};

  always_comb begin
    result = '0;
    if (ex_ld_i && ex_mask_op_i) begin
      for (int k = 0; k < data_width_c / 8; k++) begin
        result[8*k +: 8] = rd_data_i[8*k +: 8] & {8{ex_mask_i[k]}};
      end
    end else if (ex_ld_i) begin
      case (ex_size_i)
        size_byte_c: result = {{56{ex_sigext_i & shifted[7]}}, shifted[7:0]};
        size_half_c: result = {{48{ex_sigext_i & shifted[15]}}, shifted[15:0]};
        size_word_c: result = {{32{ex_sigext_i & shifted[31]}}, shifted[31:0]};
        default: result = shifted;
      endcase
    end else if (ex_taglv_i) begin
      result[1:0] = {rd_tag_i.tag.lock, rd_tag_i.tag.valid};
    end else if (ex_tagla_i) begin
      result[addr_width_c-1:byte_offset_width_c] = rd_tag_i.tag.line_addr;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_o <= 1'b0;
      data_o <= '0;
    end else begin
      v_o <= ex_v_i;
      data_o <= ex_v_i ? result : '0;
    end
  end

endmodule

`default_nettype wire

//--- source/cache_execute.sv
`default_nettype none

module cache_execute
  import cache_op_pkg::*;
  import cache_geom_pkg::*;
#(
  parameter int lines_p = 16
) (
  input  wire logic                           clk_i,
  input  wire logic                           arst_n_i,
  input  wire logic                           v_i,
  input  wire logic [addr_width_c-1:0]        addr_i,
  input  wire logic [data_width_c-1:0]        data_i,
  input  wire logic [data_width_c/8-1:0]      mask_i,
  input  wire logic [1:0]                     data_size_i,
  input  wire logic                           sigext_i,
  input  wire logic                           ld_i,
  input  wire logic                           st_i,
  input  wire logic                           mask_op_i,
  input  wire logic                           tagst_i,
  input  wire logic                           taglv_i,
  input  wire logic                           tagla_i,
  input  wire logic                           ainv_i,
  input  wire logic                           alock_i,
  input  wire logic                           aunlock_i,
  output logic                                ex_v_o,
  output logic [data_width_c-1:0]             rd_data_o,
  output pkt_data_u                           rd_tag_o,
  output logic [1:0]                          ex_size_o,
  output logic                                ex_sigext_o,
  output logic                                ex_ld_o,
  output logic                                ex_mask_op_o,
  output logic                                ex_taglv_o,
  output logic                                ex_tagla_o,
  output logic [byte_offset_width_c-1:0]      ex_offset_o,
  output logic [data_width_c/8-1:0]           ex_mask_o
);

  localparam int index_width_lp = $clog2(lines_p);
  localparam int bytes_lp = data_width_c / 8;

  logic [data_width_c-1:0] data_mem [lines_p];
  logic [line_addr_width_c-1:0] tag_addr [lines_p];
  logic [lines_p-1:0] tag_valid;
  logic [lines_p-1:0] tag_lock;

  logic [index_width_lp-1:0] index;
  logic [byte_offset_width_c-1:0] offset;
  pkt_data_u pkt_data;
  pkt_data_u tag_rd;
  logic [bytes_lp-1:0] byte_en;
  logic [data_width_c-1:0] wdata;

  assign offset = addr_i[byte_offset_width_c-1:0];
  assign index = addr_i[byte_offset_width_c +: index_width_lp];
  assign pkt_data = data_i;

  // byte lanes and replicated store data, low offset bits ignored
  always_comb begin
    byte_en = mask_i;
    wdata = pkt_data.st_data;
    if (!mask_op_i) begin
      case (data_size_i)
        size_byte_c: begin
          byte_en = 8'h01 << offset;
          wdata = {8{pkt_data.st_data[7:0]}};
        end
        size_half_c: begin
          byte_en = 8'h03 << {offset[2:1], 1'b0};
          wdata = {4{pkt_data.st_data[15:0]}};
        end
        size_word_c: begin
          byte_en = 8'h0f << {offset[2], 2'b00};
          wdata = {2{pkt_data.st_data[31:0]}};
        end
        default: byte_en = 8'hff;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < lines_p; i++) begin
        data_mem[i] <= '0;
      end
    end else if (v_i && st_i) begin
      for (int k = 0; k < bytes_lp; k++) begin
        if (byte_en[k]) begin
          data_mem[index][8*k +: 8] <= wdata[8*k +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tag_valid <= '0;
      tag_lock <= '0;
    end else if (v_i) begin
      if (tagst_i) begin
        tag_valid[index] <= pkt_data.tag.valid;
        tag_lock[index] <= pkt_data.tag.lock;
      end
      if (ainv_i) begin
        tag_valid[index] <= 1'b0;
        tag_lock[index] <= 1'b0;
      end
      if (alock_i) begin
        tag_lock[index] <= 1'b1;
      end
      if (aunlock_i) begin
        tag_lock[index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && tagst_i) begin
      tag_addr[index] <= pkt_data.tag.line_addr;
    end
  end

  always_comb begin
    tag_rd = '0;
    tag_rd.tag.lock = tag_lock[index];
    tag_rd.tag.valid = tag_valid[index];
    tag_rd.tag.line_addr = tag_addr[index];
  end

  // read before write, the word is captured on the same edge
  always_ff @(posedge clk_i) begin
    rd_data_o <= data_mem[index];
    rd_tag_o <= tag_rd;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_v_o <= 1'b0;
      ex_size_o <= size_byte_c;
      ex_sigext_o <= 1'b0;
      ex_ld_o <= 1'b0;
      ex_mask_op_o <= 1'b0;
      ex_taglv_o <= 1'b0;
      ex_tagla_o <= 1'b0;
      ex_offset_o <= '0;
      ex_mask_o <= '0;
    end else begin
      ex_v_o <= v_i;
      ex_size_o <= data_size_i;
      ex_sigext_o <= sigext_i;
      ex_ld_o <= ld_i;
      ex_mask_op_o <= mask_op_i;
      ex_taglv_o <= taglv_i;
      ex_tagla_o <= tagla_i;
      ex_offset_o <= offset;
      ex_mask_o <= mask_i;
    end
  end

endmodule

`default_nettype wire

//--- source/cache_pkt_decode.sv
`default_nettype none

module cache_pkt_decode
  import cache_op_pkg::*;
(
  input  wire logic [opcode_width_c-1:0] opcode_i,
  output logic [1:0]                     data_size_o,
  output logic                           sigext_o,
  output logic                           ld_o,
  output logic                           st_o,
  output logic                           mask_op_o,
  output logic                           tagst_o,
  output logic                           taglv_o,
  output logic                           tagla_o,
  output logic                           ainv_o,
  output logic                           alock_o,
  output logic                           aunlock_o
);

  // access size, unknown codes fall back to byte
  always_comb begin
    unique case (opcode_i)
      LB, LBU, SB: data_size_o = size_byte_c;
      LH, LHU, SH: data_size_o = size_half_c;
      LW, LWU, SW: data_size_o = size_word_c;
      LD, LDU, SD: data_size_o = size_double_c;
      default: data_size_o = size_byte_c;
    endcase
  end

  always_comb begin
    sigext_o = 1'b0;
    ld_o = 1'b0;
    st_o = 1'b0;
    mask_op_o = 1'b0;
    tagst_o = 1'b0;
    taglv_o = 1'b0;
    tagla_o = 1'b0;
    ainv_o = 1'b0;
    alock_o = 1'b0;
    aunlock_o = 1'b0;
    case (opcode_i)
      LB, LH, LW, LD: begin
        ld_o = 1'b1;
        sigext_o = 1'b1;
      end
      LBU, LHU, LWU, LDU: ld_o = 1'b1;
      SB, SH, SW, SD: st_o = 1'b1;
      LM: begin
        ld_o = 1'b1;
        mask_op_o = 1'b1;
      end
      SM: begin
        st_o = 1'b1;
        mask_op_o = 1'b1;
      end
      TAGST: tagst_o = 1'b1;
      TAGLV: taglv_o = 1'b1;
      TAGLA: tagla_o = 1'b1;
      AINV: ainv_o = 1'b1;
      ALOCK: alock_o = 1'b1;
      AUNLOCK: aunlock_o = 1'b1;
      default: begin
        // unknown opcode, no flag
        ld_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

  localparam int data_width_c = 64;
  localparam int addr_width_c = 32;
  localparam int byte_offset_width_c = 3;

  // line address is the byte address without its offset bits
  localparam int line_addr_width_c = addr_width_c - byte_offset_width_c;
  localparam int tag_pad_width_c = data_width_c - line_addr_width_c - 2;

  // packet data word, either raw store data or a tag word for TAGST
  typedef union packed {
    logic [data_width_c-1:0] st_data;
    struct packed {
      logic [tag_pad_width_c-1:0] pad;
      logic lock;
      logic valid;
      logic [line_addr_width_c-1:0] line_addr;
    } tag;
  } pkt_data_u;

endpackage

`default_nettype wire

//--- source/cache_op_pkg.sv
`default_nettype none

package cache_op_pkg;

  localparam int opcode_width_c = 5;

  // loads, signed then unsigned
  localparam logic [opcode_width_c-1:0] LB = 5'b00000;
  localparam logic [opcode_width_c-1:0] LH = 5'b00001;
  localparam logic [opcode_width_c-1:0] LW = 5'b00010;
  localparam logic [opcode_width_c-1:0] LD = 5'b00011;
  localparam logic [opcode_width_c-1:0] LBU = 5'b00100;
  localparam logic [opcode_width_c-1:0] LHU = 5'b00101;
  localparam logic [opcode_width_c-1:0] LWU = 5'b00110;
  localparam logic [opcode_width_c-1:0] LDU = 5'b00111;

  // stores and the masked pair
  localparam logic [opcode_width_c-1:0] SB = 5'b01000;
  localparam logic [opcode_width_c-1:0] SH = 5'b01001;
  localparam logic [opcode_width_c-1:0] SW = 5'b01010;
  localparam logic [opcode_width_c-1:0] SD = 5'b01011;
  localparam logic [opcode_width_c-1:0] LM = 5'b01100;
  localparam logic [opcode_width_c-1:0] SM = 5'b01101;

  // tag and address ops, codes 17, 24 and 25 stay free for flushes
  localparam logic [opcode_width_c-1:0] TAGST = 5'b10000;
  localparam logic [opcode_width_c-1:0] TAGLV = 5'b10010;
  localparam logic [opcode_width_c-1:0] TAGLA = 5'b10011;
  localparam logic [opcode_width_c-1:0] AINV = 5'b11010;
  localparam logic [opcode_width_c-1:0] ALOCK = 5'b11011;
  localparam logic [opcode_width_c-1:0] AUNLOCK = 5'b11100;

  localparam logic [1:0] size_byte_c = 2'd0;
  localparam logic [1:0] size_half_c = 2'd1;
  localparam logic [1:0] size_word_c = 2'd2;
  localparam logic [1:0] size_double_c = 2'd3;

endpackage

`default_nettype wire
